//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --assert --timing
LINT_FLAGS := --lint-only --timing
TOP        := tb_shift_unit
RTL_TOP    := shift_unit_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+include
src/shift_pkg.sv
src/shift_decode.sv
src/shift_iterative.sv
src/shift_result.sv
src/shift_unit_top.sv
testbench/tb_shift_unit.sv

//--- include/shift_cfg.svh
`ifndef SHIFT_CFG_SVH
`define SHIFT_CFG_SVH

// ####################
// Datapath sizing
// ####################

`define SHIFT_XLEN          32  // RV32I register width
`define SHIFT_AMT_W         5   // Enough bits for shifts of 0 to 31

// ####################
// Iterative shifter
// ####################

`define SHIFT_MAX_PER_CYCLE 4   // Any value from 1 to 7 fits the 3 bit step

`endif

//--- src/shift_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_cfg.svh"

module shift_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_req,
    input  shift_pkg::instr_t    in_instr,
    input  shift_pkg::xlen_t     in_rs1,
    input  shift_pkg::xlen_t     in_rs2,
    output logic                 in_ack,
    output logic                 op_valid,
    output shift_pkg::shift_op_t op,
    input  logic                 busy
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ARITH   = 7'b0100000;

    typedef enum logic [1:0] {
        WAIT_REQ,
        ACK,
        WAIT_RELEASE
    } in_state_e;

    in_state_e            state;
    logic                 hold_valid;       // op holds work not yet issued
    logic                 capture;
    shift_pkg::shift_op_t decoded;

    function automatic shift_pkg::shift_op_t decode_instr(
        input shift_pkg::instr_t instr,
        input shift_pkg::xlen_t  rs1,
        input shift_pkg::xlen_t  rs2
    );
        shift_pkg::shift_op_t d;
        logic [6:0]           opcode;
        logic [2:0]           funct3;
        logic [6:0]           funct7;

        opcode    = instr[6:0];
        funct3    = instr[14:12];
        funct7    = instr[31:25];
        d.data    = rs1;
        d.rd      = instr[11:7];
        d.kind    = shift_pkg::SHIFT_SLL;
        d.illegal = 1'b0;
        if (opcode == OPC_OP) begin
            d.amount = rs2[`SHIFT_AMT_W-1:0];                    // Register form uses rs2
        end else begin
            d.amount = shift_pkg::shamt_t'(instr[24:20]);        // Immediate shamt field
        end

        if (opcode != OPC_OP && opcode != OPC_OP_IMM) begin
            d.illegal = 1'b1;
        end else if (funct3 == F3_SLL && funct7 == F7_BASE) begin
            d.kind = shift_pkg::SHIFT_SLL;
        end else if (funct3 == F3_SR && funct7 == F7_BASE) begin
            d.kind = shift_pkg::SHIFT_SRL;
        end else if (funct3 == F3_SR && funct7 == F7_ARITH) begin
            d.kind = shift_pkg::SHIFT_SRA;
        end else begin
            d.illegal = 1'b1;
        end
        return d;
    endfunction

    always_comb decoded = decode_instr(in_instr, in_rs1, in_rs2);

    // Take a new request only with an empty slot and nothing issuing
    assign capture = (state == WAIT_REQ) && in_req && !hold_valid && !op_valid;
    assign in_ack  = (state != WAIT_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_REQ;
        end else begin
            case (state)
                WAIT_REQ:     if (capture) state <= ACK;
                ACK:          state <= WAIT_RELEASE;
                WAIT_RELEASE: if (!in_req) state <= WAIT_REQ;    // Ack drops with the request
                default:      state <= WAIT_REQ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid   <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            op_valid <= 1'b0;
            if (capture) begin
                if (busy) begin
                    hold_valid <= 1'b1;                          // Park until execute frees up
                end else begin
                    op_valid <= 1'b1;
                end
            end else if (hold_valid && !busy) begin
                op_valid   <= 1'b1;
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) op <= decoded;
    end

    // Busy only rises after our own pulse, so an issue never meets a busy shifter
    a_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) op_valid |-> !busy
    );

endmodule

`default_nettype wire

//--- src/shift_iterative.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_cfg.svh"

module shift_iterative (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_valid,
    input  shift_pkg::shift_op_t  op,
    output logic                  busy,
    output logic                  res_valid,
    output shift_pkg::shift_res_t res,
    input  logic                  full
);

    localparam int MAX_STEP = `SHIFT_MAX_PER_CYCLE;
    localparam int STEP_W   = $clog2(MAX_STEP + 1);

    typedef enum logic [1:0] {
        IDLE,
        INIT,
        SHIFT,
        DONE
    } exec_state_e;

    exec_state_e          state;
    shift_pkg::shift_op_t op_q;             // Operation latched at issue
    shift_pkg::xlen_t     shift_reg;
    shift_pkg::shamt_t    remaining;        // Shift still to be applied
    logic [STEP_W-1:0]    step;
    logic                 in_shift;

    function automatic shift_pkg::xlen_t barrel_step(
        input shift_pkg::xlen_t       data,
        input logic [STEP_W-1:0]      amount,
        input shift_pkg::shift_kind_e kind
    );
        shift_pkg::xlen_t result;

        case (kind)
            shift_pkg::SHIFT_SLL: result = data << amount;
            shift_pkg::SHIFT_SRA: result = shift_pkg::xlen_t'($signed(data) >>> amount);
            default:              result = data >> amount;
        endcase
        return result;
    endfunction

    // ####################
    // Step size
    // ####################

    always_comb begin
        if (remaining > shift_pkg::shamt_t'(MAX_STEP)) begin
            step = STEP_W'(MAX_STEP);
        end else begin
            step = remaining[STEP_W-1:0];   // Last partial step
        end
    end

    // ####################
    // Control
    // ####################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            remaining <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (op_valid) state <= INIT;
                end
                INIT: begin
                    if (op_q.illegal || op_q.amount == '0) begin
                        remaining <= '0;
                        state     <= DONE;
                    end else begin
                        remaining <= op_q.amount;
                        state     <= SHIFT;
                    end
                end
                SHIFT: begin
                    remaining <= remaining - shift_pkg::shamt_t'(step);
                    if (remaining <= shift_pkg::shamt_t'(MAX_STEP)) state <= DONE;
                end
                DONE: begin
                    if (!full) state <= IDLE;   // Result slot took the value
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ####################
    // Datapath
    // ####################

    always_ff @(posedge clk) begin
        case (state)
            IDLE:  if (op_valid) op_q <= op;
            INIT:  shift_reg <= op_q.illegal ? '0 : op_q.data;
            SHIFT: shift_reg <= barrel_step(shift_reg, step, op_q.kind);
            default: ;
        endcase
    end

    assign busy      = (state != IDLE);
    assign in_shift  = (state == SHIFT);
    assign res_valid = (state == DONE) && !full;

    always_comb begin
        res.value   = shift_reg;
        res.rd      = op_q.rd;
        res.illegal = op_q.illegal;
    end

    a_remaining_shrinks: assert property (
        @(posedge clk) disable iff (!rst_n) in_shift |=> remaining < $past(remaining)
    );

    // Worst case is a 31 bit shift at one bit per cycle
    a_shift_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(in_shift) |-> ##[1:`SHIFT_XLEN] !in_shift
    );

endmodule

`default_nettype wire

//--- src/shift_pkg.sv
`default_nettype none

`include "shift_cfg.svh"

package shift_pkg;

    // ####################
    // Basic vectors
    // ####################

    typedef logic [`SHIFT_XLEN-1:0]  xlen_t;
    typedef logic [`SHIFT_AMT_W-1:0] shamt_t;
    typedef logic [4:0]              reg_idx_t;
    typedef logic [31:0]             instr_t;

    typedef enum logic [1:0] {
        SHIFT_SLL = 2'd0,                   // Logical left
        SHIFT_SRL = 2'd1,                   // Logical right
        SHIFT_SRA = 2'd2                    // Arithmetic right
    } shift_kind_e;

    // ####################
    // Stage payloads
    // ####################

    typedef struct packed {
        xlen_t       data;                  // Value from rs1
        shamt_t      amount;
        shift_kind_e kind;
        reg_idx_t    rd;
        logic        illegal;               // Not a valid RV32I shift
    } shift_op_t;

    typedef struct packed {
        xlen_t    value;
        reg_idx_t rd;
        logic     illegal;
    } shift_res_t;

endpackage

`default_nettype wire

//--- src/shift_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_cfg.svh"

module shift_result (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  res_valid,
    input  shift_pkg::shift_res_t res,
    output logic                  full,
    output logic                  out_req,
    output shift_pkg::shift_res_t out_res,
    input  logic                  out_ack
);

    typedef enum logic [1:0] {
        EMPTY,
        REQ,
        RELEASE
    } out_state_e;

    out_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY:   if (res_valid) state <= REQ;
                REQ:     if (out_ack) state <= RELEASE;    // Consumer has the value
                RELEASE: if (!out_ack) state <= EMPTY;     // Handshake closed
                default: state <= EMPTY;
            endcase
        end
    end

    // ####################
    // Result slot
    // ####################

    always_ff @(posedge clk) begin
        if (res_valid) out_res <= res;
    end

    assign full    = (state != EMPTY);
    assign out_req = (state == REQ);

    a_out_res_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> out_res == $past(out_res)
    );

endmodule

`default_nettype wire

//--- src/shift_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_cfg.svh"

module shift_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_req,
    input  shift_pkg::instr_t     in_instr,
    input  shift_pkg::xlen_t      in_rs1,
    input  shift_pkg::xlen_t      in_rs2,
    output logic                  in_ack,
    output logic                  out_req,
    output shift_pkg::shift_res_t out_res,
    input  logic                  out_ack
);

    logic                  op_valid;
    shift_pkg::shift_op_t  op;
    logic                  busy;
    logic                  res_valid;
    shift_pkg::shift_res_t res;
    logic                  full;

    shift_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_ack   (in_ack),
        .op_valid (op_valid),
        .op       (op),
        .busy     (busy)
    );

    shift_iterative u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res),
        .full      (full)
    );

    shift_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res       (res),
        .full      (full),
        .out_req   (out_req),
        .out_res   (out_res),
        .out_ack   (out_ack)
    );

endmodule

`default_nettype wire

//--- testbench/tb_shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "shift_cfg.svh"

module tb_shift_unit;

    localparam int         TIMEOUT    = 200;
    localparam int         STREAM_LEN = 40;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] F7_ARITH   = 7'b0100000;

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    shift_pkg::instr_t     in_instr;
    shift_pkg::xlen_t      in_rs1;
    shift_pkg::xlen_t      in_rs2;
    logic                  in_ack;
    logic                  out_req;
    shift_pkg::shift_res_t out_res;
    logic                  out_ack;
    integer                seed;
    int                    errors;

    shift_unit_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_res  (out_res),
        .out_ack  (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ####################
    // Reference model
    // ####################

    function automatic shift_pkg::instr_t encode_instr(
        input logic [6:0] f7,
        input logic [4:0] f_rs2,
        input logic [4:0] f_rs1,
        input logic [2:0] f3,
        input logic [4:0] rd,
        input logic [6:0] opc
    );
        return {f7, f_rs2, f_rs1, f3, rd, opc};
    endfunction

    function automatic shift_pkg::shift_res_t shift_model(
        input shift_pkg::instr_t instr,
        input shift_pkg::xlen_t  rs1,
        input shift_pkg::xlen_t  rs2
    );
        shift_pkg::shift_res_t r;
        logic [4:0]            amt;

        r.rd      = instr[11:7];
        r.illegal = 1'b0;
        r.value   = '0;
        amt       = (instr[6:0] == OPC_OP) ? rs2[4:0] : instr[24:20];
        if (instr[6:0] != OPC_OP && instr[6:0] != OPC_IMM) begin
            r.illegal = 1'b1;
        end else if (instr[14:12] == 3'b001 && instr[31:25] == 7'd0) begin
            r.value = rs1 << amt;
        end else if (instr[14:12] == 3'b101 && instr[31:25] == 7'd0) begin
            r.value = rs1 >> amt;                           // Zero fill
        end else if (instr[14:12] == 3'b101 && instr[31:25] == F7_ARITH) begin
            r.value = $signed(rs1) >>> amt;                 // Sign fill
        end else begin
            r.illegal = 1'b1;
        end
        return r;
    endfunction

    // ####################
    // Handshakes
    // ####################

    task automatic check_field(input string name, input logic [`SHIFT_XLEN-1:0] got,
                               input logic [`SHIFT_XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic send_instr(input shift_pkg::instr_t instr, input shift_pkg::xlen_t rs1,
                              input shift_pkg::xlen_t rs2);
        int n;

        in_instr <= instr;
        in_rs1   <= rs1;
        in_rs2   <= rs2;
        in_req   <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!in_ack && n < TIMEOUT);
        if (!in_ack) begin
            errors++;
            $display("Timeout at %0t: in_ack never rose after in_req", $time);
        end
        in_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (in_ack && n < TIMEOUT);
        if (in_ack) begin
            errors++;
            $display("Timeout at %0t: in_ack stayed high after in_req fell", $time);
        end
    endtask

    task automatic receive_result(input shift_pkg::shift_res_t exp, input int ack_delay);
        shift_pkg::shift_res_t seen;
        int                    n;

        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!out_req && n < TIMEOUT);
        if (!out_req) begin
            errors++;
            $display("Timeout at %0t: no result came out for rd %0d", $time, exp.rd);
            return;
        end
        seen = out_res;
        check_field("out_res.value", seen.value, exp.value);
        check_field("out_res.rd", shift_pkg::xlen_t'(seen.rd), shift_pkg::xlen_t'(exp.rd));
        check_field("out_res.illegal", shift_pkg::xlen_t'(seen.illegal),
                    shift_pkg::xlen_t'(exp.illegal));
        repeat (ack_delay) begin
            @(posedge clk);
            if (out_res !== seen) begin                     // Must hold until out_ack
                errors++;
                $display("FAILED at %0t: out_res expected %h got %h", $time, seen, out_res);
            end
        end
        out_ack <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (out_req && n < TIMEOUT);
        if (out_req) begin
            errors++;
            $display("Timeout at %0t: out_req stayed high after out_ack", $time);
        end
        out_ack <= 1'b0;
    endtask

    task automatic single_shift(input shift_pkg::instr_t instr, input shift_pkg::xlen_t rs1,
                                input shift_pkg::xlen_t rs2);
        send_instr(instr, rs1, rs2);
        receive_result(shift_model(instr, rs1, rs2), 3);
    endtask

    // ####################
    // Directed tests
    // ####################

    task automatic check_after_reset;
        if (in_ack !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: in_ack expected 0 got %b", $time, in_ack);
        end
        if (out_req !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: out_req expected 0 got %b", $time, out_req);
        end
        single_shift(encode_instr(7'd0, 5'd3, 5'd1, 3'b001, 5'd5, OPC_IMM), 32'h0000_00ff, '0);
    endtask

    task automatic left_shift_cases;
        int          amounts[6] = '{0, 1, 3, 4, 5, 31};
        logic [31:0] rnd;
        logic [4:0]  amt;

        foreach (amounts[i]) begin
            amt = 5'(amounts[i]);
            rnd = $random(seed);
            single_shift(encode_instr(7'd0, 5'd2, 5'd1, 3'b001, amt + 5'd1, OPC_OP),
                         32'hc3a5_0f17, {rnd[31:5], amt});  // Upper rs2 bits are ignored
            single_shift(encode_instr(7'd0, amt, 5'd1, 3'b001, 5'd31 - amt, OPC_IMM),
                         rnd, 32'hffff_ffff);
        end
    endtask

    task automatic right_shift_cases;
        shift_pkg::xlen_t data[2]    = '{32'h8765_4321, 32'h1234_5678};
        int               amounts[3] = '{0, 7, 31};
        logic [4:0]       amt;

        foreach (data[d]) begin
            foreach (amounts[a]) begin
                amt = 5'(amounts[a]);
                single_shift(encode_instr(7'd0, 5'd3, 5'd1, 3'b101, 5'd10, OPC_OP),
                             data[d], {27'h7ff_ffff, amt});
                single_shift(encode_instr(F7_ARITH, 5'd3, 5'd1, 3'b101, 5'd11, OPC_OP),
                             data[d], {27'h0, amt});
                single_shift(encode_instr(7'd0, amt, 5'd1, 3'b101, 5'd12, OPC_IMM), data[d], '0);
                single_shift(encode_instr(F7_ARITH, amt, 5'd1, 3'b101, 5'd13, OPC_IMM),
                             data[d], '0);
            end
        end
    endtask

    task automatic illegal_cases;
        single_shift(encode_instr(7'd0, 5'd2, 5'd1, 3'b000, 5'd9, OPC_OP),
                     32'h0000_0011, 32'h0000_0022);         // ADD
        single_shift(encode_instr(F7_ARITH, 5'd4, 5'd1, 3'b001, 5'd12, OPC_IMM),
                     32'hdead_beef, '0);                    // SLLI with bit 30 set
    endtask

    task automatic random_stream;
        shift_pkg::instr_t instrs[STREAM_LEN];
        shift_pkg::xlen_t  rs1s[STREAM_LEN];
        shift_pkg::xlen_t  rs2s[STREAM_LEN];
        int                delays[STREAM_LEN];
        logic [31:0]       rnd;
        int                form;

        for (int i = 0; i < STREAM_LEN; i++) begin
            rnd = $random(seed);
            form = int'(rnd % 32'd6);                       // SLL SRL SRA SLLI SRLI SRAI
            instrs[i] = encode_instr((form == 2 || form == 5) ? F7_ARITH : 7'd0,
                                     rnd[12:8], rnd[17:13],
                                     (form == 0 || form == 3) ? 3'b001 : 3'b101,
                                     rnd[22:18], (form < 3) ? OPC_OP : OPC_IMM);
            rs1s[i] = $random(seed);
            rs2s[i] = $random(seed);
            rnd = $random(seed);
            delays[i] = int'(rnd[3:0]);
        end
        fork
            for (int i = 0; i < STREAM_LEN; i++) send_instr(instrs[i], rs1s[i], rs2s[i]);
            for (int j = 0; j < STREAM_LEN; j++) begin
                receive_result(shift_model(instrs[j], rs1s[j], rs2s[j]), delays[j]);
            end
        join
    endtask

    initial begin
        seed     = 32'hba36_d25f;
        errors   = 0;
        rst_n    = 1'b0;
        in_req   = 1'b0;
        in_instr = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        out_ack  = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_after_reset;
        left_shift_cases;
        right_shift_cases;
        illegal_cases;
        random_stream;
        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
